//--- flist.f
src/clk_cal_pkg.sv
src/cal_regs.sv
src/cal_channel.sv
src/cal_status.sv
src/clk_cal_top.sv
sim/clk_cal_sva.sv
sim/tb_clk_cal.sv

//--- Makefile
# Verilator build and run of tb_clk_cal

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_clk_cal -Mdir obj_dir -o tb_clk_cal -f flist.f
	./obj_dir/tb_clk_cal > sim.log 2>&1 || echo "TB FAILED" >> sim.log
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_clk_cal.sv
`timescale 1ns/100ps
`default_nettype none
// ----------------------------------------------------------
// directed tests for clk_cal_top with two channels
// oscillator models follow a linear half period rule, so
// an expected trim is exact only to within one code
// ----------------------------------------------------------

module tb_clk_cal
    import clk_cal_pkg::*;
;

    localparam int  NUM_CH      = 2;
    localparam int  CLK_NS      = 8;
    localparam int  REF_NS      = 1000;            // clk_32k period
    localparam int  REF_PERIODS = 100;             // window per step
    localparam real GAIN0       = 0.2;             // ns of half period per code
    localparam real GAIN1       = 0.3;
    localparam int  STEP_NS     = int'(SETTLE_CYCLES) * CLK_NS + (REF_PERIODS + 2) * REF_NS;
    localparam int  CAL_NS      = TRIM_W * STEP_NS;
    localparam int  CAL_RUNS    = 3;
    localparam int  POLL_GAP    = 100;             // cycles between flag polls
    localparam int  MAX_POLLS   = 2 * CAL_NS / (POLL_GAP * CLK_NS);
    localparam int  STEP_LIMIT  = 2 * STEP_NS / CLK_NS;

    logic                        clk_rc32m = 1'b0;
    logic                        clk_32k   = 1'b0;
    logic                        osc0      = 1'b0;
    logic                        osc1      = 1'b0;
    logic                        prst_n;
    logic [ADDR_W-1:0]           paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [DATA_W-1:0]           pwdata;
    logic [DATA_W-1:0]           prdata;
    logic                        pready;
    logic                        pslverr;
    logic [NUM_CH*TRIM_W-1:0]    freq_sel;
    logic                        irq;
    logic                        slv_err;
    integer                      seed = 27;
    int                          value_errs = 0;
    int                          other_errs = 0;

    clk_cal_top #(
        .NUM_CH     (NUM_CH)
    ) dut_i (
        .clk_rc32m  (clk_rc32m),
        .prst_n     (prst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .clk_32k    (clk_32k),
        .osc_in     ({osc1, osc0}),
        .freq_sel   (freq_sel),
        .irq        (irq)
    );

    // ----------------------------------------------------------
    // clocks and oscillator models
    // ----------------------------------------------------------
    always
    begin
        #(CLK_NS / 2);
        clk_rc32m = ~clk_rc32m;
    end

    always
    begin
        #(REF_NS / 2);
        clk_32k = ~clk_32k;
    end

    // higher code, shorter half period
    function automatic real half_period_ns(input int code, input real gain);
        return 20.0 + real'((2 ** TRIM_W - 1) - code) * gain;
    endfunction

    always
    begin
        #(half_period_ns(int'(freq_sel[TRIM_W-1:0]), GAIN0));
        osc0 = ~osc0;
    end

    always
    begin
        #(half_period_ns(int'(freq_sel[2*TRIM_W-1:TRIM_W]), GAIN1));
        osc1 = ~osc1;
    end

    // ----------------------------------------------------------
    // reference model of the search
    // ----------------------------------------------------------
    function automatic real ideal_count(input int code, input real gain);
        return real'(REF_PERIODS * REF_NS) / (2.0 * half_period_ns(code, gain));
    endfunction

    function automatic logic [TRIM_W-1:0] expected_code(input int target, input real gain);
        logic [TRIM_W-1:0] code;
        logic [TRIM_W-1:0] trial;
        code  = TRIM_RST;
        trial = TRIM_RST;
        for (int k = 0; k < TRIM_W; k++)
        begin
            if (ideal_count(int'(code), gain) > real'(target))
                code = code & ~trial;   // too fast, drop the bit
            trial = trial >> 1;
            code  = code | trial;
        end
        return code;
    endfunction

    // codes 96..240, where a code step is several counts
    function automatic int pick_target(input real gain);
        int code;
        code = 96 + int'({$random(seed)} % 145);
        return $rtoi(ideal_count(code, gain));
    endfunction

    // ----------------------------------------------------------
    // APB master
    // ----------------------------------------------------------
    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic err);
        @(negedge clk_rc32m);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_rc32m);
        penable = 1'b1;
        #2;
        err = pslverr;
        check_bit("pready", pready, 1'b1);
        @(negedge clk_rc32m);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output cal_word_u data,
                            output logic err);
        @(negedge clk_rc32m);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_rc32m);
        penable = 1'b1;
        #2;                                 // settled read data
        data = prdata;
        err  = pslverr;
        check_bit("pready", pready, 1'b1);
        @(negedge clk_rc32m);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_slot(input int ch, input int target);
        cal_word_u w;
        w = '0;
        w.cfg.target_count = CNT_W'(target);
        w.cfg.ref_periods  = PER_W'(REF_PERIODS);
        apb_write(CH_BASE_OFS + ADDR_W'(ch) * CH_STRIDE, w, slv_err);
    endtask

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_word(input string name, input cal_word_u got, input cal_word_u exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_trim(input string name, input logic [TRIM_W-1:0] got,
                              input logic [TRIM_W-1:0] exp, input int tol);
        int diff;
        diff = int'(got) - int'(exp);
        if ($isunknown(got) || diff > tol || diff < -tol)
        begin
            $display("ERROR %s: got 0x%02h, expected 0x%02h within %0d", name, got, exp, tol);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got 0x%01h, expected 0x%01h", name, got, exp);
            value_errs++;
        end
    endtask

    // poll IRQ until every bit of mask is set
    task automatic wait_flags(input logic [NUM_CH-1:0] mask);
        cal_word_u rd;
        int        polls;
        rd    = '0;
        polls = 0;
        while (((rd[NUM_CH-1:0] & mask) != mask) && polls < MAX_POLLS)
        begin
            repeat (POLL_GAP) @(negedge clk_rc32m);
            apb_read(IRQ_OFS, rd, slv_err);
            polls++;
        end
        if ((rd[NUM_CH-1:0] & mask) != mask)
        begin
            $display("calibration did not finish, done flags %0h never came", mask);
            other_errs++;
        end
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic test_reset_state();
        cal_word_u rd;
        check_trim("freq_sel byte 0", freq_sel[TRIM_W-1:0], TRIM_RST, 0);
        check_trim("freq_sel byte 1", freq_sel[2*TRIM_W-1:TRIM_W], TRIM_RST, 0);
        check_bit("irq", irq, 1'b0);
        apb_read(CTRL_OFS, rd, slv_err);
        check_word("ctrl", rd, '0);
        apb_read(IRQ_OFS, rd, slv_err);
        check_word("irq flags", rd, '0);
        for (int i = 0; i < NUM_CH; i++)
        begin
            apb_read(CH_BASE_OFS + ADDR_W'(i) * CH_STRIDE, rd, slv_err);
            check_word("channel slot", rd, '0);
        end
    endtask

    task automatic test_unmapped();
        cal_word_u rd;
        apb_read(12'h018, rd, slv_err);       // one slot past the last channel
        check_bit("pslverr unmapped read", slv_err, 1'b1);
        check_word("prdata unmapped read", rd, '0);
        apb_write(12'h0f0, 32'hffff_ffff, slv_err);
        check_bit("pslverr unmapped write", slv_err, 1'b1);
        apb_read(IRQ_OFS, rd, slv_err);
        check_bit("pslverr mapped read", slv_err, 1'b0);
    endtask

    task automatic test_single_channel();
        int                target;
        logic [TRIM_W-1:0] exp_code;
        cal_word_u         rd;
        target   = pick_target(GAIN0);
        exp_code = expected_code(target, GAIN0);
        write_slot(0, target);
        apb_write(CTRL_OFS, 32'h1, slv_err);
        apb_read(CTRL_OFS, rd, slv_err);
        check_word("ctrl busy", rd, 32'h1);
        wait_flags(2'b01);
        check_bit("irq", irq, 1'b1);
        apb_read(IRQ_OFS, rd, slv_err);
        check_word("irq flags", rd, 32'h1);
        apb_read(CH_BASE_OFS, rd, slv_err);
        check_trim("ch0 res trim", rd.res.trim, exp_code, 1);
        check_trim("freq_sel byte 0", freq_sel[TRIM_W-1:0], rd.res.trim, 0);
        check_bit("ch0 res busy", rd.res.busy, 1'b0);
        apb_read(CTRL_OFS, rd, slv_err);
        check_word("ctrl after done", rd, '0);
        apb_write(IRQ_OFS, 32'h1, slv_err);
        check_bit("irq after clear", irq, 1'b0);
    endtask

    task automatic test_dual_channel();
        int                target0;
        int                target1;
        logic [TRIM_W-1:0] exp0;
        logic [TRIM_W-1:0] exp1;
        cal_word_u         rd;
        target0 = pick_target(GAIN0);
        target1 = pick_target(GAIN1);
        exp0    = expected_code(target0, GAIN0);
        exp1    = expected_code(target1, GAIN1);
        write_slot(0, target0);
        write_slot(1, target1);
        apb_write(CTRL_OFS, 32'h3, slv_err);
        wait_flags(2'b11);
        apb_read(IRQ_OFS, rd, slv_err);
        check_word("irq flags", rd, 32'h3);
        apb_read(CH_BASE_OFS, rd, slv_err);
        check_trim("ch0 res trim", rd.res.trim, exp0, 1);
        apb_read(CH_BASE_OFS + CH_STRIDE, rd, slv_err);
        check_trim("ch1 res trim", rd.res.trim, exp1, 1);
        check_trim("freq_sel byte 1", freq_sel[2*TRIM_W-1:TRIM_W], rd.res.trim, 0);
    endtask

    task automatic test_irq_clear_and_restart();
        int                target;
        int                n;
        logic [TRIM_W-1:0] exp_code;
        logic [TRIM_W-1:0] step_code;
        cal_word_u         rd;
        apb_write(IRQ_OFS, 32'h1, slv_err);
        apb_read(IRQ_OFS, rd, slv_err);
        check_word("irq flags after ch0 clear", rd, 32'h2);
        check_bit("irq with ch1 flag left", irq, 1'b1);
        apb_write(IRQ_OFS, 32'h2, slv_err);
        apb_read(IRQ_OFS, rd, slv_err);
        check_word("irq flags after ch1 clear", rd, '0);
        check_bit("irq with no flags", irq, 1'b0);

        target   = pick_target(GAIN0);
        exp_code = expected_code(target, GAIN0);
        write_slot(0, target);
        apb_write(CTRL_OFS, 32'h1, slv_err);
        // first step boundary moves the code off mid scale
        n = 0;
        while (freq_sel[TRIM_W-1:0] == TRIM_RST && n < STEP_LIMIT)
        begin
            @(negedge clk_rc32m);
            n++;
        end
        if (n >= STEP_LIMIT)
        begin
            $display("first search step of channel 0 never ended");
            other_errs++;
        end
        step_code = freq_sel[TRIM_W-1:0];
        apb_write(CTRL_OFS, 32'h1, slv_err);  // ignored while busy
        check_trim("freq_sel after second start", freq_sel[TRIM_W-1:0], step_code, 0);
        wait_flags(2'b01);
        apb_read(IRQ_OFS, rd, slv_err);
        check_word("irq flags after restart", rd, 32'h1);
        apb_read(CH_BASE_OFS, rd, slv_err);
        check_trim("ch0 res trim after restart", rd.res.trim, exp_code, 1);
        apb_write(IRQ_OFS, 32'h1, slv_err);
    endtask

    // ----------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------
    initial
    begin
        prst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (8) @(posedge clk_rc32m);
        @(negedge clk_rc32m);
        prst_n = 1'b1;

        test_reset_state();
        test_unmapped();
        test_single_channel();
        test_dual_channel();
        test_irq_clear_and_restart();

        $display("run complete: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #(2 * CAL_RUNS * CAL_NS);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/clk_cal_sva.sv
`timescale 1ns/100ps
`default_nettype none
// ----------------------------------------------------------
// bus and channel handshake properties, bound to clk_cal_top
// ----------------------------------------------------------

module clk_cal_sva
    import clk_cal_pkg::*;
#(
    parameter int NUM_CH = 2
)
(
    input  logic                        clk_rc32m,
    input  logic                        prst_n,
    input  logic                        pready,
    input  logic                        irq,
    input  logic [NUM_CH*TRIM_W-1:0]    freq_sel,
    input  logic [NUM_CH-1:0]           busy,
    input  logic [NUM_CH-1:0]           done,
    input  logic [NUM_CH-1:0]           flags
);

    pready_high: assert property (@(posedge clk_rc32m) disable iff (!prst_n) pready)
        else $error("pready low, slave has no wait states");

    done_in_busy: assert property (@(posedge clk_rc32m) disable iff (!prst_n)
        (done & ~busy) == '0)
        else $error("done pulse from an idle channel");

    // trims only move during a search
    trim_quiet: assert property (@(posedge clk_rc32m) disable iff (!prst_n)
        (busy == '0) && ($past(busy) == '0) |-> $stable(freq_sel))
        else $error("freq_sel changed with no channel busy");

    irq_is_or: assert property (@(posedge clk_rc32m) disable iff (!prst_n)
        irq == (|flags))
        else $error("irq does not match the done flags");

endmodule

bind clk_cal_top clk_cal_sva #(
    .NUM_CH     (NUM_CH)
) sva_i (
    .clk_rc32m  (clk_rc32m),
    .prst_n     (prst_n),
    .pready     (pready),
    .irq        (irq),
    .freq_sel   (freq_sel),
    .busy       (ch_busy),
    .done       (ch_done),
    .flags      (ch_flags)
);

`default_nettype wire

//--- src/clk_cal_top.sv
`timescale 1ns/100ps
`default_nettype none
// ----------------------------------------------------------
// RC oscillator calibration, all logic on clk_rc32m
// freq_sel packs channel trims, channel 0 in the low byte
// ----------------------------------------------------------

module clk_cal_top
    import clk_cal_pkg::*;
#(
    parameter int NUM_CH = 2
)
(
    input  logic                        clk_rc32m,
    input  logic                        prst_n,
    // APB
    input  logic [ADDR_W-1:0]           paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [DATA_W-1:0]           pwdata,
    output logic [DATA_W-1:0]           prdata,
    output logic                        pready,
    output logic                        pslverr,
    // reference and oscillators
    input  logic                        clk_32k,
    input  logic [NUM_CH-1:0]           osc_in,
    output logic [NUM_CH*TRIM_W-1:0]    freq_sel,
    output logic                        irq
);

    logic [NUM_CH-1:0]               ch_start;
    logic [NUM_CH-1:0]               ch_busy;
    logic [NUM_CH-1:0]               ch_done;
    logic [NUM_CH-1:0]               ch_irq_clr;
    logic [NUM_CH-1:0]               ch_flags;
    logic [NUM_CH-1:0][CNT_W-1:0]    ch_target;
    logic [NUM_CH-1:0][PER_W-1:0]    ch_periods;
    logic [NUM_CH-1:0][TRIM_W-1:0]   ch_trim;
    logic [NUM_CH-1:0][CNT_W-1:0]    ch_count;
    cal_word_u [NUM_CH-1:0]          ch_res;

    cal_regs #(
        .NUM_CH         (NUM_CH)
    ) regs_i (
        .clk_rc32m      (clk_rc32m),
        .prst_n         (prst_n),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .busy           (ch_busy),
        .irq_flags      (ch_flags),
        .res_word       (ch_res),
        .start          (ch_start),
        .irq_clr        (ch_irq_clr),
        .target_count   (ch_target),
        .ref_periods    (ch_periods)
    );

    for (genvar i = 0; i < NUM_CH; i++)
    begin : g_ch
        cal_channel ch_i (
            .clk_rc32m      (clk_rc32m),
            .prst_n         (prst_n),
            .start          (ch_start[i]),
            .target_count   (ch_target[i]),
            .ref_periods    (ch_periods[i]),
            .clk_32k        (clk_32k),
            .osc_in         (osc_in[i]),
            .trim           (ch_trim[i]),
            .busy           (ch_busy[i]),
            .done           (ch_done[i]),
            .measured_count (ch_count[i])
        );
    end

    cal_status #(
        .NUM_CH         (NUM_CH)
    ) status_i (
        .clk_rc32m      (clk_rc32m),
        .prst_n         (prst_n),
        .busy           (ch_busy),
        .done           (ch_done),
        .trim           (ch_trim),
        .measured_count (ch_count),
        .irq_clr        (ch_irq_clr),
        .irq_flags      (ch_flags),
        .res_word       (ch_res),
        .irq            (irq)
    );

    assign freq_sel = ch_trim;

endmodule

`default_nettype wire

//--- src/cal_status.sv
`timescale 1ns/100ps
`default_nettype none
// ----------------------------------------------------------
// per channel result latches and sticky done flags
// set wins over a clear in the same cycle
// ----------------------------------------------------------

module cal_status
    import clk_cal_pkg::*;
#(
    parameter int NUM_CH = 2
)
(
    input  logic                            clk_rc32m,
    input  logic                            prst_n,
    input  logic [NUM_CH-1:0]               busy,
    input  logic [NUM_CH-1:0]               done,
    input  logic [NUM_CH-1:0][TRIM_W-1:0]   trim,
    input  logic [NUM_CH-1:0][CNT_W-1:0]    measured_count,
    input  logic [NUM_CH-1:0]               irq_clr,
    output logic [NUM_CH-1:0]               irq_flags,
    output cal_word_u [NUM_CH-1:0]          res_word,
    output logic                            irq
);

    logic [NUM_CH-1:0][TRIM_W-1:0]  trim_q;
    logic [NUM_CH-1:0][CNT_W-1:0]   count_q;

    // results of the last finished search
    always_ff @(posedge clk_rc32m or negedge prst_n)
    begin
        if (!prst_n)
        begin
            trim_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_CH; i++)
            begin
                if (done[i])
                begin
                    trim_q[i]  <= trim[i];
                    count_q[i] <= measured_count[i];
                end
            end
        end
    end

    always_ff @(posedge clk_rc32m or negedge prst_n)
    begin
        if (!prst_n)
            irq_flags <= '0;
        else
            irq_flags <= done | (irq_flags & ~irq_clr);
    end

    // res view with live busy
    always_comb
    begin
        for (int i = 0; i < NUM_CH; i++)
        begin
            res_word[i]                    = '0;
            res_word[i].res.measured_count = count_q[i];
            res_word[i].res.busy           = busy[i];
            res_word[i].res.trim           = trim_q[i];
        end
    end

    assign irq = |irq_flags;

endmodule

`default_nettype wire

//--- src/cal_channel.sv
`timescale 1ns/100ps
`default_nettype none
// ----------------------------------------------------------
// SAR trim search for one RC oscillator against clk_32k
// osc_in and clk_32k must stay below a quarter of clk_rc32m
// edge count saturates, so a very fast osc still reads fast
// ----------------------------------------------------------

module cal_channel
    import clk_cal_pkg::*;
(
    input  logic               clk_rc32m,
    input  logic               prst_n,
    input  logic               start,
    input  logic [CNT_W-1:0]   target_count,
    input  logic [PER_W-1:0]   ref_periods,
    input  logic               clk_32k,
    input  logic               osc_in,
    output logic [TRIM_W-1:0]  trim,
    output logic               busy,
    output logic               done,
    output logic [CNT_W-1:0]   measured_count
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_SETTLE  = 3'd1;
    localparam logic [2:0] ST_ALIGN   = 3'd2;   // wait for ref rising edge
    localparam logic [2:0] ST_MEASURE = 3'd3;
    localparam logic [2:0] ST_DONE    = 3'd4;

    logic [2:0]                        ref_sync;    // 2 sync stages + history
    logic [2:0]                        osc_sync;
    logic                              ref_rise;
    logic                              osc_rise;
    logic [2:0]                        state;
    logic [$bits(SETTLE_CYCLES)-1:0]   settle_cnt;
    logic [PER_W-1:0]                  per_cnt;
    logic [CNT_W-1:0]                  edge_cnt;
    logic [CNT_W-1:0]                  step_count;
    logic [TRIM_W-1:0]                 trial_bit;   // one hot, bit under test
    logic [TRIM_W-1:0]                 kept_trim;
    logic                              step_end;
    logic                              fast;

    // ----------------------------------------------------------
    // synchronizers and edge detect
    // ----------------------------------------------------------
    always_ff @(posedge clk_rc32m or negedge prst_n)
    begin
        if (!prst_n)
        begin
            ref_sync <= '0;
            osc_sync <= '0;
        end
        else
        begin
            ref_sync <= {ref_sync[1:0], clk_32k};
            osc_sync <= {osc_sync[1:0], osc_in};
        end
    end

    assign ref_rise = ref_sync[1] & ~ref_sync[2];
    assign osc_rise = osc_sync[1] & ~osc_sync[2];

    // ----------------------------------------------------------
    // step result
    // ----------------------------------------------------------
    // include an edge landing on the closing ref edge
    assign step_count = (osc_rise && (edge_cnt != '1)) ? edge_cnt + 1'b1 : edge_cnt;

    // ref_periods of zero behaves as a single period
    assign step_end = (state == ST_MEASURE) && ref_rise &&
                      (per_cnt + PER_W'(1) >= ref_periods);

    assign fast      = (step_count > target_count);            // osc too fast
    assign kept_trim = fast ? (trim & ~trial_bit) : trim;

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

    // ----------------------------------------------------------
    // search FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_rc32m or negedge prst_n)
    begin
        if (!prst_n)
        begin
            state      <= ST_IDLE;
            trim       <= TRIM_RST;
            trial_bit  <= TRIM_RST;
            settle_cnt <= '0;
            per_cnt    <= '0;
            edge_cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        trim       <= TRIM_RST;     // first trial is the top bit
                        trial_bit  <= TRIM_RST;
                        settle_cnt <= '0;
                        state      <= ST_SETTLE;
                    end
                end
                ST_SETTLE:
                begin
                    if (settle_cnt == SETTLE_CYCLES - 1'b1)
                        state <= ST_ALIGN;
                    else
                        settle_cnt <= settle_cnt + 1'b1;
                end
                ST_ALIGN:
                begin
                    if (ref_rise)
                    begin
                        edge_cnt <= '0;
                        per_cnt  <= '0;
                        state    <= ST_MEASURE;
                    end
                end
                ST_MEASURE:
                begin
                    edge_cnt <= step_count;
                    if (step_end)
                    begin
                        if (trial_bit[0])
                        begin
                            trim  <= kept_trim;     // last bit decided
                            state <= ST_DONE;
                        end
                        else
                        begin
                            // next lower bit becomes the trial bit
                            trim       <= kept_trim | (trial_bit >> 1);
                            trial_bit  <= trial_bit >> 1;
                            settle_cnt <= '0;
                            state      <= ST_SETTLE;
                        end
                    end
                    else if (ref_rise)
                        per_cnt <= per_cnt + 1'b1;
                end
                ST_DONE:
                    state <= ST_IDLE;               // one cycle done pulse
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // count of the most recent step
    always_ff @(posedge clk_rc32m or negedge prst_n)
    begin
        if (!prst_n)
            measured_count <= '0;
        else if (step_end)
            measured_count <= step_count;
    end

endmodule

`default_nettype wire

//--- src/cal_regs.sv
`timescale 1ns/100ps
`default_nettype none
// ----------------------------------------------------------
// APB slave, no wait states, single cycle access phase
// unmapped addresses answer pslverr with zero read data
// ----------------------------------------------------------

module cal_regs
    import clk_cal_pkg::*;
#(
    parameter int NUM_CH = 2
)
(
    input  logic                            clk_rc32m,
    input  logic                            prst_n,
    // APB
    input  logic [ADDR_W-1:0]               paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [DATA_W-1:0]               pwdata,
    output logic [DATA_W-1:0]               prdata,
    output logic                            pready,
    output logic                            pslverr,
    // from channels and status block
    input  logic [NUM_CH-1:0]               busy,
    input  logic [NUM_CH-1:0]               irq_flags,
    input  cal_word_u [NUM_CH-1:0]          res_word,
    // to channels and status block
    output logic [NUM_CH-1:0]               start,
    output logic [NUM_CH-1:0]               irq_clr,
    output logic [NUM_CH-1:0][CNT_W-1:0]    target_count,
    output logic [NUM_CH-1:0][PER_W-1:0]    ref_periods
);

    logic                acc;
    logic                wr_acc;
    logic                rd_acc;
    logic                ctrl_hit;
    logic                irq_hit;
    logic [NUM_CH-1:0]   slot_hit;
    logic                map_hit;
    cal_word_u           wdata_w;
    logic [DATA_W-1:0]   rdata_mux;

    // ----------------------------------------------------------
    // access phase and decode
    // ----------------------------------------------------------
    assign acc    = psel & penable;
    assign wr_acc = acc & pwrite;
    assign rd_acc = acc & ~pwrite;

    assign wdata_w = pwdata;

    assign ctrl_hit = (paddr == CTRL_OFS);
    assign irq_hit  = (paddr == IRQ_OFS);

    // one slot per channel, word aligned
    always_comb
    begin
        for (int i = 0; i < NUM_CH; i++)
        begin
            slot_hit[i] = (paddr == CH_BASE_OFS + ADDR_W'(i) * CH_STRIDE);
        end
    end

    assign map_hit = ctrl_hit | irq_hit | (|slot_hit);

    assign pready  = 1'b1;
    assign pslverr = acc & ~map_hit;

    // ----------------------------------------------------------
    // pulses, live only in the access cycle
    // ----------------------------------------------------------
    assign start   = (wr_acc && ctrl_hit) ? pwdata[NUM_CH-1:0] : '0;
    assign irq_clr = (wr_acc && irq_hit) ? pwdata[NUM_CH-1:0] : '0;   // one bit per written one

    // ----------------------------------------------------------
    // channel config registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_rc32m or negedge prst_n)
    begin
        if (!prst_n)
        begin
            target_count <= '0;
            ref_periods  <= '0;
        end
        else if (wr_acc)
        begin
            for (int i = 0; i < NUM_CH; i++)
            begin
                if (slot_hit[i])
                begin
                    target_count[i] <= wdata_w.cfg.target_count;
                    ref_periods[i]  <= wdata_w.cfg.ref_periods;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // read mux
    // ----------------------------------------------------------
    always_comb
    begin
        rdata_mux = '0;
        if (ctrl_hit)
            rdata_mux = DATA_W'(busy);          // busy bits
        else if (irq_hit)
            rdata_mux = DATA_W'(irq_flags);
        for (int i = 0; i < NUM_CH; i++)
        begin
            if (slot_hit[i])
                rdata_mux = res_word[i];        // res view
        end
    end

    // bus is quiet outside read accesses
    assign prdata = rd_acc ? rdata_mux : '0;

endmodule

`default_nettype wire

//--- src/clk_cal_pkg.sv
`default_nettype none
// ----------------------------------------------------------
// shared widths, register map and slot word layout
// slot words assume DATA_W of 32 and the widths below
// ----------------------------------------------------------

package clk_cal_pkg;

    // ----------------------------------------------------------
    // bus and datapath widths
    // ----------------------------------------------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int CNT_W  = 16;     // target and measured count
    localparam int TRIM_W = 8;
    localparam int PER_W  = 8;      // reference window length

    // search starts from mid scale
    localparam logic [TRIM_W-1:0] TRIM_RST = 8'h80;

    // wait after each trim change before counting
    localparam logic [7:0] SETTLE_CYCLES = 8'd15;

    // ----------------------------------------------------------
    // register map
    // ----------------------------------------------------------
    localparam logic [ADDR_W-1:0] CTRL_OFS    = 12'h000;  // start / busy
    localparam logic [ADDR_W-1:0] IRQ_OFS     = 12'h004;  // flags, w1c
    localparam logic [ADDR_W-1:0] CH_BASE_OFS = 12'h010;  // channel 0 slot
    localparam logic [ADDR_W-1:0] CH_STRIDE   = 12'd4;

    // ----------------------------------------------------------
    // channel slot word
    // ----------------------------------------------------------
    // written as cfg, read back as res
    typedef union packed {
        struct packed {
            logic [CNT_W-1:0]  target_count;
            logic [PER_W-1:0]  ref_periods;   // reference periods per step
            logic [7:0]        rsvd;
        } cfg;
        struct packed {
            logic [CNT_W-1:0]  measured_count;  // count of last step
            logic [6:0]        rsvd;
            logic              busy;
            logic [TRIM_W-1:0] trim;            // final code of last search
        } res;
    } cal_word_u;

endpackage

`default_nettype wire
